// File: cmac_pkg.sv
package cmac_pkg;

  //====================================================================
  // widths
  //====================================================================
  localparam int CMAC_OP_W   = 16;   // operand word
  localparam int CMAC_LANE_W = 8;    // one int8 lane
  localparam int CMAC_RES_W  = 32;   // redundant result word
  localparam int CMAC_PP_NUM = 8;    // radix-4 rows for a 16 bit operand
  localparam int CMAC_PP_W   = 17;   // selector row incl. inverted sign
  localparam int CMAC_ROW_W0 = 24;   // level-0 tree, four rows at 2 bit steps
  localparam int CMAC_ROW_W1 = 32;   // level-1 tree

  //====================================================================
  // gate constants
  //====================================================================
  // sum of the 2^16 sign offsets of rows 0..7 at their radix-4 weights
  localparam logic [CMAC_RES_W-1:0]   CMAC_BIAS16 = 32'h5555_0000;
  // same for four 9 bit rows of one lane
  localparam logic [CMAC_RES_W/2-1:0] CMAC_BIAS8  = 16'h5500;

  //====================================================================
  // operand and result views
  //====================================================================
  typedef union packed {
    logic signed [CMAC_OP_W-1:0] val;          // int16 view
    struct packed {
      logic signed [CMAC_LANE_W-1:0] hi;       // lane 1
      logic signed [CMAC_LANE_W-1:0] lo;       // lane 0
    } lane;
  } cmac_op_u;

  typedef union packed {
    logic [CMAC_RES_W-1:0]             word;   // int16 carry-save word
    logic [1:0][CMAC_RES_W/2-1:0]      half;   // per lane halves
  } cmac_res_u;

endpackage

// File: cmac_pp_if.sv
`timescale 1ns/1ps

// booth rows from the encoder to the reduction tree
interface cmac_pp_if;
  import cmac_pkg::*;

  // row k is weighted by 4^k inside its group
  logic [CMAC_PP_NUM-1:0][CMAC_PP_W-1:0] pp_data;  // one's-complement rows
  logic [CMAC_PP_NUM-1:0]                pp_inv;   // +1 still owed per negative row

  // encoder side
  modport enc (
    output pp_data,
    output pp_inv
  );

  // reduction side
  modport red (
    input  pp_data,
    input  pp_inv
  );

endinterface

// File: cmac_mul_ctrl.sv
`timescale 1ns/1ps

module cmac_mul_ctrl (
  input  logic       nvdla_core_clk,
  input  logic       nvdla_core_rstn,
  input  logic       cfg_is_int8,
  input  logic       cfg_reg_en,
  input  logic [1:0] op_a_nz,
  input  logic [1:0] op_b_nz,
  input  logic       op_a_pvld,
  input  logic       op_b_pvld,
  output logic       is_int8,
  output logic [1:0] lane_vld
);

  //====================================================================
  // config register
  //====================================================================
  // mode follows cfg_is_int8 one edge after cfg_reg_en
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      is_int8 <= 1'b0;            // int16 out of reset
    end else if (cfg_reg_en) begin
      is_int8 <= cfg_is_int8;
    end
  end

  //====================================================================
  // lane valid
  //====================================================================
  // both operands present and both bytes nonzero
  always_comb begin
    for (int k = 0; k < 2; k++) begin
      lane_vld[k] = op_a_pvld & op_b_pvld & op_a_nz[k] & op_b_nz[k];
    end
  end

  //====================================================================
  // checks
  //====================================================================
  // an unknown enable would corrupt the mode register
  a_cfg_en_known: assert property (
    @(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    !$isunknown(cfg_reg_en)
  ) else $error("cfg_reg_en is X or Z outside reset");

  // int16 rows span both halves so the halves must gate together
  a_int16_lane_match: assert property (
    @(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    !is_int8 |-> (lane_vld[0] == lane_vld[1])
  ) else $error("lane valids differ in int16 mode");

endmodule

// File: cmac_booth_sel.sv
`timescale 1ns/1ps

module cmac_booth_sel (
  input  logic [2:0]                    code,       // {a[2i+1], a[2i], a[2i-1]}
  input  logic                          is_8bit,
  input  logic [cmac_pkg::CMAC_OP_W-1:0] src_data,
  output logic [cmac_pkg::CMAC_PP_W-1:0] out_data,
  output logic                          out_inv
);
  import cmac_pkg::*;

  // rows carry the inverted sign on top so no sign extension is needed
  // negative rows are one's complement with out_inv as the missing +1
  always_comb begin
    case ({is_8bit, code})
      //================================================================
      // 16 bit source
      //================================================================
      4'b0000, 4'b0111: begin               // zero
        out_data = {1'b1, {CMAC_OP_W{1'b0}}};
        out_inv  = 1'b0;
      end
      4'b0001, 4'b0010: begin               // +1x
        out_data = {~src_data[15], src_data};
        out_inv  = 1'b0;
      end
      4'b0101, 4'b0110: begin               // -1x
        out_data = {src_data[15], ~src_data};
        out_inv  = 1'b1;
      end
      4'b0011: begin                        // +2x
        out_data = {~src_data[15], src_data[14:0], 1'b0};
        out_inv  = 1'b0;
      end
      4'b0100: begin                        // -2x, lsb is ~0
        out_data = {src_data[15], ~src_data[14:0], 1'b1};
        out_inv  = 1'b1;
      end
      //================================================================
      // 8 bit source, upper byte of the row left clear
      //================================================================
      4'b1000, 4'b1111: begin
        out_data = {{CMAC_LANE_W{1'b0}}, 1'b1, {CMAC_LANE_W{1'b0}}};
        out_inv  = 1'b0;
      end
      4'b1001, 4'b1010: begin
        out_data = {{CMAC_LANE_W{1'b0}}, ~src_data[7], src_data[7:0]};
        out_inv  = 1'b0;
      end
      4'b1101, 4'b1110: begin
        out_data = {{CMAC_LANE_W{1'b0}}, src_data[7], ~src_data[7:0]};
        out_inv  = 1'b1;
      end
      4'b1011: begin
        out_data = {{CMAC_LANE_W{1'b0}}, ~src_data[7], src_data[6:0], 1'b0};
        out_inv  = 1'b0;
      end
      4'b1100: begin
        out_data = {{CMAC_LANE_W{1'b0}}, src_data[7], ~src_data[6:0], 1'b1};
        out_inv  = 1'b1;
      end
      default: begin                        // only reachable on X
        out_data = {1'b1, {CMAC_OP_W{1'b0}}};
        out_inv  = 1'b0;
      end
    endcase
  end

endmodule

// File: cmac_booth_enc.sv
`timescale 1ns/1ps

module cmac_booth_enc (
  input  logic               is_int8,
  input  cmac_pkg::cmac_op_u op_a_dat,
  input  cmac_pkg::cmac_op_u op_b_dat,
  cmac_pp_if.enc             pp
);
  import cmac_pkg::*;

  logic [CMAC_LANE_W:0]        code_lo;   // 9 bit window, rows 0..3
  logic [CMAC_LANE_W:0]        code_hi;   // 9 bit window, rows 4..7
  logic [CMAC_PP_NUM-1:0][2:0] code;      // overlapping triples
  logic [CMAC_OP_W-1:0]        src_lo;    // b for rows 0..3
  logic [CMAC_OP_W-1:0]        src_hi;    // b for rows 4..7

  //====================================================================
  // booth windows on operand a
  //====================================================================
  assign code_lo = {op_a_dat.lane.lo, 1'b0};

  // int16 chains on from bit 7, int8 starts a fresh lane
  assign code_hi = is_int8 ? {op_a_dat.lane.hi, 1'b0}
                           : op_a_dat.val[CMAC_OP_W-1:CMAC_LANE_W-1];

  always_comb begin
    for (int k = 0; k < CMAC_PP_NUM / 2; k++) begin
      code[k]                   = code_lo[2*k +: 3];
      code[k + CMAC_PP_NUM / 2] = code_hi[2*k +: 3];
    end
  end

  //====================================================================
  // selector sources on operand b
  //====================================================================
  assign src_lo = is_int8 ? {{CMAC_LANE_W{1'b0}}, op_b_dat.lane.lo} : op_b_dat.val;
  assign src_hi = is_int8 ? {{CMAC_LANE_W{1'b0}}, op_b_dat.lane.hi} : op_b_dat.val;

  //====================================================================
  // eight selectors
  //====================================================================
  for (genvar k = 0; k < CMAC_PP_NUM; k++) begin : g_sel
    cmac_booth_sel u_sel (
      .code     (code[k]),
      .is_8bit  (is_int8),
      .src_data ((k < CMAC_PP_NUM / 2) ? src_lo : src_hi),   // lane split
      .out_data (pp.pp_data[k]),
      .out_inv  (pp.pp_inv[k])
    );
  end

endmodule

// File: cmac_csa_tree.sv
`timescale 1ns/1ps

// carry-save reduction of num_rows words to two
// out0 + out1 == sum of rows, modulo 2^row_w
module cmac_csa_tree #(
  parameter int num_rows = 5,
  parameter int row_w    = 24
) (
  input  logic [num_rows-1:0][row_w-1:0] rows,
  output logic [row_w-1:0]               out0,
  output logic [row_w-1:0]               out1
);

  if (num_rows == 1) begin : g_one
    // nothing left to add
    assign out0 = rows[0];
    assign out1 = '0;
  end else if (num_rows == 2) begin : g_two
    // done, hand the pair on in redundant form
    assign out0 = rows[0];
    assign out1 = rows[1];
  end else begin : g_round
    // one round of 3:2 compressors
    // each full triple becomes sum + carry, leftovers pass through
    logic [2*(num_rows/3)+num_rows%3-1:0][row_w-1:0] nxt;

    for (genvar g = 0; g < num_rows / 3; g++) begin : g_csa
      // bitwise full adder sum
      assign nxt[2*g] = rows[3*g] ^ rows[3*g+1] ^ rows[3*g+2];
      // majority moved up one bit, top carry falls off
      assign nxt[2*g+1] = ((rows[3*g] & rows[3*g+1]) |
                           (rows[3*g] & rows[3*g+2]) |
                           (rows[3*g+1] & rows[3*g+2])) << 1;
    end

    for (genvar r = 0; r < num_rows % 3; r++) begin : g_pass
      assign nxt[2*(num_rows/3)+r] = rows[3*(num_rows/3)+r];
    end

    // next round on the shorter stack
    cmac_csa_tree #(
      .num_rows (2 * (num_rows / 3) + num_rows % 3),
      .row_w    (row_w)
    ) u_next (
      .rows (nxt),
      .out0 (out0),
      .out1 (out1)
    );
  end

endmodule

// File: cmac_mul_reduce.sv
`timescale 1ns/1ps

module cmac_mul_reduce (
  input  logic                is_int8,
  input  logic [1:0]          lane_vld,
  cmac_pp_if.red              pp,
  output cmac_pkg::cmac_res_u res_a,
  output cmac_pkg::cmac_res_u res_b
);
  import cmac_pkg::*;

  // five level-0 inputs per group, four rows plus one trailing inv bit
  logic [CMAC_PP_NUM/2:0][CMAC_ROW_W0-1:0] l0_in_lo;   // rows 0..3
  logic [CMAC_PP_NUM/2:0][CMAC_ROW_W0-1:0] l0_in_hi;   // rows 4..7
  logic [CMAC_ROW_W0-1:0] l0_lo_0;
  logic [CMAC_ROW_W0-1:0] l0_lo_1;
  logic [CMAC_ROW_W0-1:0] l0_hi_0;
  logic [CMAC_ROW_W0-1:0] l0_hi_1;
  logic [3:0][CMAC_ROW_W1-1:0] l1_in;
  logic [CMAC_ROW_W1-1:0] l1_0;
  logic [CMAC_ROW_W1-1:0] l1_1;
  cmac_res_u res_a_ori;
  cmac_res_u res_b_ori;
  cmac_res_u res_a_gate;

  //====================================================================
  // row placement
  //====================================================================
  always_comb begin
    l0_in_lo[0] = CMAC_ROW_W0'(pp.pp_data[0]);
    l0_in_hi[0] = CMAC_ROW_W0'(pp.pp_data[CMAC_PP_NUM/2]);
    for (int k = 1; k < CMAC_PP_NUM / 2; k++) begin
      // row at 2k, inv of the row below sits at that row's lsb
      l0_in_lo[k] = (CMAC_ROW_W0'(pp.pp_data[k]) << (2 * k)) |
                    (CMAC_ROW_W0'(pp.pp_inv[k-1]) << (2 * k - 2));
      l0_in_hi[k] = (CMAC_ROW_W0'(pp.pp_data[k+CMAC_PP_NUM/2]) << (2 * k)) |
                    (CMAC_ROW_W0'(pp.pp_inv[k+CMAC_PP_NUM/2-1]) << (2 * k - 2));
    end
    // last row of each group owes its own +1
    l0_in_lo[CMAC_PP_NUM/2] = CMAC_ROW_W0'(pp.pp_inv[CMAC_PP_NUM/2-1]) << (CMAC_PP_NUM - 2);
    l0_in_hi[CMAC_PP_NUM/2] = CMAC_ROW_W0'(pp.pp_inv[CMAC_PP_NUM-1]) << (CMAC_PP_NUM - 2);
  end

  cmac_csa_tree #(.num_rows(CMAC_PP_NUM/2 + 1), .row_w(CMAC_ROW_W0)) u_tree_l0_lo (
    .rows (l0_in_lo),
    .out0 (l0_lo_0),
    .out1 (l0_lo_1)
  );

  cmac_csa_tree #(.num_rows(CMAC_PP_NUM/2 + 1), .row_w(CMAC_ROW_W0)) u_tree_l0_hi (
    .rows (l0_in_hi),
    .out0 (l0_hi_0),
    .out1 (l0_hi_1)
  );

  //====================================================================
  // level 1, int16 only
  //====================================================================
  always_comb begin
    l1_in = '0;                                   // quiet in int8
    if (!is_int8) begin
      l1_in[0] = CMAC_ROW_W1'(l0_lo_0);
      l1_in[1] = CMAC_ROW_W1'(l0_lo_1);
      l1_in[2] = CMAC_ROW_W1'(l0_hi_0) << CMAC_LANE_W;   // rows 4..7 weigh 2^8
      l1_in[3] = CMAC_ROW_W1'(l0_hi_1) << CMAC_LANE_W;
    end
  end

  cmac_csa_tree #(.num_rows(4), .row_w(CMAC_ROW_W1)) u_tree_l1 (
    .rows (l1_in),
    .out0 (l1_0),
    .out1 (l1_1)
  );

  //====================================================================
  // mode select and lane gating
  //====================================================================
  always_comb begin
    if (is_int8) begin
      res_a_ori.half[1] = l0_hi_0[CMAC_RES_W/2-1:0];
      res_a_ori.half[0] = l0_lo_0[CMAC_RES_W/2-1:0];
      res_b_ori.half[1] = l0_hi_1[CMAC_RES_W/2-1:0];
      res_b_ori.half[0] = l0_lo_1[CMAC_RES_W/2-1:0];
    end else begin
      res_a_ori.word = l1_0;
      res_b_ori.word = l1_1;
    end
  end

  // gate keeps the bias so a dead lane still sums to product zero
  assign res_a_gate.word = is_int8 ? {CMAC_BIAS8, CMAC_BIAS8} : CMAC_BIAS16;

  always_comb begin
    for (int h = 0; h < 2; h++) begin
      res_a.half[h] = lane_vld[h] ? res_a_ori.half[h] : res_a_gate.half[h];
      res_b.half[h] = lane_vld[h] ? res_b_ori.half[h] : '0;
    end
  end

endmodule

// File: cmac_mul_top.sv
`timescale 1ns/1ps

module cmac_mul_top (
  input  logic                nvdla_core_clk,
  input  logic                nvdla_core_rstn,
  input  logic                cfg_is_int8,
  input  logic                cfg_reg_en,
  input  cmac_pkg::cmac_op_u  op_a_dat,
  input  logic [1:0]          op_a_nz,
  input  logic                op_a_pvld,
  input  cmac_pkg::cmac_op_u  op_b_dat,
  input  logic [1:0]          op_b_nz,
  input  logic                op_b_pvld,
  output cmac_pkg::cmac_res_u res_a,     // carry-save pair
  output cmac_pkg::cmac_res_u res_b
);

  logic       is_int8;    // registered mode
  logic [1:0] lane_vld;   // per half

  cmac_pp_if u_pp_if ();  // booth rows

  cmac_mul_ctrl u_ctrl (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .cfg_is_int8     (cfg_is_int8),
    .cfg_reg_en      (cfg_reg_en),
    .op_a_nz         (op_a_nz),
    .op_b_nz         (op_b_nz),
    .op_a_pvld       (op_a_pvld),
    .op_b_pvld       (op_b_pvld),
    .is_int8         (is_int8),
    .lane_vld        (lane_vld)
  );

  cmac_booth_enc u_enc (
    .is_int8  (is_int8),
    .op_a_dat (op_a_dat),
    .op_b_dat (op_b_dat),
    .pp       (u_pp_if.enc)
  );

  cmac_mul_reduce u_reduce (
    .is_int8  (is_int8),
    .lane_vld (lane_vld),
    .pp       (u_pp_if.red),
    .res_a    (res_a),
    .res_b    (res_b)
  );

endmodule

// File: tb_clk_gen.sv
`timescale 1ns/1ps

// clock and power-on reset for the testbench
module tb_clk_gen #(
  parameter int half_period = 5,    // ns, gives a 10 ns clock
  parameter int rst_cycles  = 8
) (
  output logic nvdla_core_clk,
  output logic nvdla_core_rstn
);

  initial begin
    nvdla_core_clk = 1'b0;
    forever #half_period nvdla_core_clk = ~nvdla_core_clk;
  end

  initial begin
    nvdla_core_rstn = 1'b0;
    repeat (rst_cycles) @(posedge nvdla_core_clk);
    nvdla_core_rstn <= 1'b1;        // release on an edge, like the drivers
  end

endmodule

// File: cmac_mul_tb.sv
`timescale 1ns/1ps

module cmac_mul_tb;
  import cmac_pkg::*;

  localparam int RST_CYC   = 8;
  localparam int N_ROWS    = 18;
  localparam int N_RAND    = 200;             // per mode
  localparam int N_SWITCH  = 8;               // mode switch and latch cycles
  localparam int CYC_LIMIT = 2 * (RST_CYC + N_ROWS + 2 * N_RAND + N_SWITCH);

  typedef struct packed {
    logic        mode;      // 1 = int8
    logic [15:0] a;
    logic [15:0] b;
    logic [1:0]  a_nz;
    logic [1:0]  b_nz;
    logic        a_pvld;
    logic        b_pvld;
  } vec_t;

  //====================================================================
  // directed vectors
  //====================================================================
  localparam vec_t TBL [N_ROWS] = '{
    '{1'b0, 16'h7fff, 16'h7fff, 2'b11, 2'b11, 1'b1, 1'b1},  // max * max
    '{1'b0, 16'h8000, 16'h8000, 2'b11, 2'b11, 1'b1, 1'b1},  // min * min
    '{1'b0, 16'h8000, 16'h7fff, 2'b11, 2'b11, 1'b1, 1'b1},
    '{1'b0, 16'hffff, 16'hffff, 2'b11, 2'b11, 1'b1, 1'b1},  // -1 * -1
    '{1'b0, 16'h0000, 16'h1234, 2'b11, 2'b11, 1'b1, 1'b1},  // zero
    '{1'b0, 16'h0001, 16'h8000, 2'b11, 2'b11, 1'b1, 1'b1},
    '{1'b0, 16'hffff, 16'h7fff, 2'b11, 2'b11, 1'b1, 1'b1},
    '{1'b0, 16'h1234, 16'hedcb, 2'b11, 2'b11, 1'b1, 1'b1},
    '{1'b0, 16'h7fff, 16'h7fff, 2'b11, 2'b11, 1'b0, 1'b1},  // a not valid
    '{1'b0, 16'h1234, 16'h5678, 2'b00, 2'b11, 1'b1, 1'b1},  // a zero flags
    '{1'b1, 16'h7f80, 16'h807f, 2'b11, 2'b11, 1'b1, 1'b1},  // mixed signs
    '{1'b1, 16'hff80, 16'hff80, 2'b11, 2'b11, 1'b1, 1'b1},
    '{1'b1, 16'h7f01, 16'h7fff, 2'b11, 2'b11, 1'b1, 1'b1},
    '{1'b1, 16'h853c, 16'h21c4, 2'b11, 2'b11, 1'b1, 1'b1},
    '{1'b1, 16'h7f80, 16'h807f, 2'b01, 2'b11, 1'b1, 1'b1},  // lane 1 off
    '{1'b1, 16'h7f80, 16'h807f, 2'b10, 2'b11, 1'b1, 1'b1},  // lane 0 off
    '{1'b1, 16'h7f80, 16'h807f, 2'b11, 2'b11, 1'b1, 1'b0},  // b not valid
    '{1'b0, 16'h8001, 16'h7fff, 2'b11, 2'b11, 1'b1, 1'b1}
  };

  logic       nvdla_core_clk;
  logic       nvdla_core_rstn;
  logic       cfg_is_int8;
  logic       cfg_reg_en;
  cmac_op_u   op_a_dat;
  cmac_op_u   op_b_dat;
  logic [1:0] op_a_nz;
  logic [1:0] op_b_nz;
  logic       op_a_pvld;
  logic       op_b_pvld;
  cmac_res_u  res_a;
  cmac_res_u  res_b;

  logic        cur_mode;                // mode the DUT should be in
  logic [31:0] rng = 32'hff9c_80d3;
  int          n_checks   = 0;
  int          exact_errs = 0;
  int          sum_errs   = 0;
  int          lane_errs  = 0;
  int          cyc        = 0;

  tb_clk_gen #(.half_period(5), .rst_cycles(RST_CYC)) u_clk_gen (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn)
  );

  cmac_mul_top uut (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .cfg_is_int8     (cfg_is_int8),
    .cfg_reg_en      (cfg_reg_en),
    .op_a_dat        (op_a_dat),
    .op_a_nz         (op_a_nz),
    .op_a_pvld       (op_a_pvld),
    .op_b_dat        (op_b_dat),
    .op_b_nz         (op_b_nz),
    .op_b_pvld       (op_b_pvld),
    .res_a           (res_a),
    .res_b           (res_b)
  );

  // watchdog
  always @(posedge nvdla_core_clk) begin
    cyc <= cyc + 1;
    if (cyc >= CYC_LIMIT) begin
      $display("timeout: run did not end within %0d cycles", CYC_LIMIT);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  //====================================================================
  // compare tasks
  //====================================================================
  task automatic check_res(input cmac_res_u got, input cmac_res_u exp, input string what);
    n_checks++;
    if (got.word !== exp.word) begin
      exact_errs++;
      $display("Error at %0t: %s got %h, expected %h", $time, what, got.word, exp.word);
    end
  endtask

  // int16 pair must sum to product plus bias
  task automatic check_sum16(input cmac_res_u ra, input cmac_res_u rb,
                             input logic [31:0] prod, input string what);
    logic [31:0] sum;
    logic [31:0] exp;
    sum = ra.word + rb.word;
    exp = prod + CMAC_BIAS16;
    n_checks++;
    if (sum !== exp) begin
      sum_errs++;
      $display("Error at %0t: %s sum %h, expected %h", $time, what, sum, exp);
    end
  endtask

  // one int8 half, summed when valid, exact gate values when not
  task automatic check_lane(input cmac_res_u ra, input cmac_res_u rb, input int h,
                            input logic vld, input logic [15:0] prod, input string what);
    logic [15:0] sum;
    logic [15:0] exp;
    sum = ra.half[h] + rb.half[h];
    exp = prod + CMAC_BIAS8;
    n_checks++;
    if (vld && sum !== exp) begin
      lane_errs++;
      $display("Error at %0t: %s lane %0d sum %h, expected %h", $time, what, h, sum, exp);
    end else if (!vld && (ra.half[h] !== CMAC_BIAS8 || rb.half[h] !== 16'h0000)) begin
      lane_errs++;
      $display("Error at %0t: %s lane %0d gate %h/%h, expected %h/0000",
               $time, what, h, ra.half[h], rb.half[h], CMAC_BIAS8);
    end
  endtask

  //====================================================================
  // drive and expect
  //====================================================================
  task automatic apply_vec(input logic en, input logic cfg, input cmac_op_u a,
                           input cmac_op_u b, input logic [1:0] anz, input logic [1:0] bnz,
                           input logic apv, input logic bpv);
    @(posedge nvdla_core_clk);
    cfg_reg_en  <= en;
    cfg_is_int8 <= cfg;
    op_a_dat    <= a;
    op_b_dat    <= b;
    op_a_nz     <= anz;
    op_b_nz     <= bnz;
    op_a_pvld   <= apv;
    op_b_pvld   <= bpv;
    @(negedge nvdla_core_clk);            // outputs settled, next edge far away
  endtask

  task automatic check_vec(input logic m, input cmac_op_u a, input cmac_op_u b,
                           input logic [1:0] anz, input logic [1:0] bnz,
                           input logic apv, input logic bpv);
    logic [1:0]         vld;
    logic signed [31:0] ax;
    logic signed [31:0] bx;
    logic signed [15:0] la;
    logic signed [15:0] lb;
    cmac_res_u          exp;
    string              ctx;
    ctx = $sformatf("%s a %h b %h", m ? "int8" : "int16", a.val, b.val);
    vld = {2{apv & bpv}} & anz & bnz;     // a lane needs both operands present
    if (!m) begin
      if (vld == 2'b11) begin
        ax = {{16{a.val[15]}}, a.val};
        bx = {{16{b.val[15]}}, b.val};
        check_sum16(res_a, res_b, ax * bx, ctx);
      end else begin
        exp.word = CMAC_BIAS16;
        check_res(res_a, exp, {ctx, " res_a"});
        exp.word = '0;
        check_res(res_b, exp, {ctx, " res_b"});
      end
    end else begin
      for (int h = 0; h < 2; h++) begin
        la = h ? {{8{a.lane.hi[7]}}, a.lane.hi} : {{8{a.lane.lo[7]}}, a.lane.lo};
        lb = h ? {{8{b.lane.hi[7]}}, b.lane.hi} : {{8{b.lane.lo[7]}}, b.lane.lo};
        check_lane(res_a, res_b, h, vld[h], la * lb, ctx);
      end
    end
  endtask

  // idle enable cycle, old mode still visible in it
  task automatic switch_mode(input logic m);
    cmac_op_u z;
    z.val = '0;
    apply_vec(1'b1, m, z, z, 2'b00, 2'b00, 1'b0, 1'b0);
    check_vec(cur_mode, z, z, 2'b00, 2'b00, 1'b0, 1'b0);
    cur_mode = m;
  endtask

  // cfg_is_int8 moves first with the enable low, then with it high
  task automatic latch_test;
    cmac_op_u a;
    cmac_op_u b;
    logic     old;
    old   = cur_mode;
    a.val = 16'h0102;                     // int16 and int8 reads differ
    b.val = 16'h0304;
    apply_vec(1'b0, ~old, a, b, 2'b11, 2'b11, 1'b1, 1'b1);
    check_vec(old, a, b, 2'b11, 2'b11, 1'b1, 1'b1);
    apply_vec(1'b1, ~old, a, b, 2'b11, 2'b11, 1'b1, 1'b1);
    check_vec(old, a, b, 2'b11, 2'b11, 1'b1, 1'b1);
    apply_vec(1'b0, ~old, a, b, 2'b11, 2'b11, 1'b1, 1'b1);
    check_vec(~old, a, b, 2'b11, 2'b11, 1'b1, 1'b1);
    cur_mode = ~old;
  endtask

  task automatic run_random(input logic m);
    logic [31:0] r1;
    logic [31:0] r2;
    cmac_op_u    a;
    cmac_op_u    b;
    logic [1:0]  anz;
    logic [1:0]  bnz;
    logic        apv;
    logic        bpv;
    if (cur_mode != m) switch_mode(m);
    for (int n = 0; n < N_RAND; n++) begin
      rng   = xorshift32(rng);
      r1    = rng;
      rng   = xorshift32(rng);
      r2    = rng;
      a.val = r1[15:0];
      b.val = r1[31:16];
      if (m) begin
        anz = r2[1:0] | r2[3:2];          // lanes independent
        bnz = r2[5:4] | r2[7:6];
      end else begin
        anz = (r2[2:0] == 3'd0) ? 2'b00 : 2'b11;   // int16 halves move together
        bnz = (r2[5:3] == 3'd0) ? 2'b00 : 2'b11;
      end
      apv = r2[8] | r2[9];
      bpv = r2[10] | r2[11];
      apply_vec(1'b0, m, a, b, anz, bnz, apv, bpv);
      check_vec(m, a, b, anz, bnz, apv, bpv);
    end
  endtask

  //====================================================================
  // main sequence
  //====================================================================
  initial begin
    cmac_op_u  a;
    cmac_op_u  b;
    cmac_res_u exp;
    cfg_is_int8 = 1'b0;
    cfg_reg_en  = 1'b0;
    op_a_dat    = '0;
    op_b_dat    = '0;
    op_a_nz     = 2'b00;
    op_b_nz     = 2'b00;
    op_a_pvld   = 1'b0;
    op_b_pvld   = 1'b0;
    cur_mode    = 1'b0;                   // int16 out of reset
    wait (nvdla_core_rstn === 1'b1);
    @(negedge nvdla_core_clk);
    exp.word = CMAC_BIAS16;
    check_res(res_a, exp, "after reset res_a");
    exp.word = '0;
    check_res(res_b, exp, "after reset res_b");
    for (int i = 0; i < N_ROWS; i++) begin
      if (TBL[i].mode != cur_mode) switch_mode(TBL[i].mode);
      a.val = TBL[i].a;
      b.val = TBL[i].b;
      apply_vec(1'b0, cur_mode, a, b, TBL[i].a_nz, TBL[i].b_nz,
                TBL[i].a_pvld, TBL[i].b_pvld);
      check_vec(cur_mode, a, b, TBL[i].a_nz, TBL[i].b_nz, TBL[i].a_pvld, TBL[i].b_pvld);
    end
    latch_test();
    run_random(1'b0);
    run_random(1'b1);
    $display("checks %0d, errors exact %0d, sum16 %0d, lane %0d",
             n_checks, exact_errs, sum_errs, lane_errs);
    if (exact_errs + sum_errs + lane_errs == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// File: cmac_mul.f
cmac_pkg.sv
cmac_pp_if.sv
cmac_mul_ctrl.sv
cmac_booth_sel.sv
cmac_booth_enc.sv
cmac_csa_tree.sv
cmac_mul_reduce.sv
cmac_mul_top.sv
tb_clk_gen.sv
cmac_mul_tb.sv

// File: Makefile
# Verilator flow for the cmac multiplier testbench

TOP := cmac_mul_tb
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f cmac_mul.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f cmac_mul.f \
		-Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "ALL CHECKS PASSED" $(LOG) || (echo "simulation ended early"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
